/* compile.f */
common/uart_pkg.sv
uart_tx/uart_baud_gen.sv
uart_tx/uart_tx.sv
source/uart_rx.sv
source/uart_apb_regs.sv
source/uart_top.sv
test/uart_tb_clock.sv
test/uart_tb.sv

/* Makefile */
SRCS := $(shell cat compile.f)

obj_dir/Vuart_tb: compile.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module uart_tb -f compile.f

run: obj_dir/Vuart_tb
	./obj_dir/Vuart_tb | tee sim.log
	grep -q "Simulation completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* test/uart_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tb;

	localparam int CLK_DIV   = 16;
	localparam int MAX_POLLS = 200;          // STATUS reads, three cycles each
	localparam int FRAME_TO  = 14 * CLK_DIV; // Cycles allowed for one txd frame

	logic                clk;
	logic                rstn;
	uart_pkg::apb_req_t  apb_req;
	uart_pkg::apb_rsp_t  apb_rsp;
	logic                txd;
	logic                rxd;
	logic                loopback;               // rxd follows txd
	logic                drv_rxd;                // Direct line level
	integer              seed = 32'h4f3d_7d44;
	int                  errors = 0;
	int                  checks = 0;
	int                  tests = 0;
	int                  test_err0 = 0;          // Errors before the current test
	int                  cyc = 0;
	int                  acc_cyc;                // Cycle count just after the last access
	uart_pkg::apb_data_t rdata;
	logic                slverr;
	logic [9:0]          frame;
	logic                first;
	logic                width_ok;
	uart_pkg::byte_t     mon_byte;
	logic                mon_stop;
	logic                mon_width_ok;
	int                  mon_start_cyc;
	int                  mon_count = 0;
	uart_pkg::byte_t     b0;
	uart_pkg::byte_t     b1;

	assign rxd = loopback ? txd : drv_rxd;

	always @(posedge clk) cyc <= cyc + 1;

	uart_tb_clock u_clock (
		.clk (clk),
		.rstn(rstn)
	);

	uart_top #(
		.CLK_DIV(CLK_DIV)
	) u_uart_top (
		.clk    (clk),
		.rstn   (rstn),
		.apb_req(apb_req),
		.rxd    (rxd),
		.apb_rsp(apb_rsp),
		.txd    (txd)
	);

	// No wait states on this slave
	pready_high: assert property (@(posedge clk) disable iff (!rstn) apb_rsp.pready)
		else begin
			$display("[FAIL] %0t apb_rsp.pready got 0 expected 1", $time);
			errors++;
		end

	slverr_in_access: assert property (@(posedge clk) disable iff (!rstn)
		apb_rsp.pslverr |-> apb_req.psel && apb_req.penable)
		else begin
			$display("[FAIL] %0t apb_rsp.pslverr got 1 expected 0 outside access", $time);
			errors++;
		end

	// Rebuilds each txd frame, every bit must hold for CLK_DIV cycles
	initial begin
		forever begin
			@(negedge clk);
			if (rstn && !txd) begin
				mon_start_cyc = cyc;
				width_ok      = 1'b1;
				for (int b = 0; b < 10; b++) begin
					for (int c = 0; c < CLK_DIV; c++) begin
						if (b + c > 0)
							@(negedge clk);
						if (c == 0)
							first = txd;
						else if (txd !== first)
							width_ok = 1'b0; // Edge inside a bit
						if (c == CLK_DIV / 2)
							frame[b] = txd;  // Mid-bit sample
					end
				end
				mon_byte     = frame[8:1];
				mon_stop     = frame[9];
				mon_width_ok = width_ok && !frame[0];
				mon_count++;                 // Last, so the byte is already there
			end
		end
	end

	function automatic uart_pkg::byte_t rand_byte();
		integer r;
		r = $random(seed);
		return r[7:0];
	endfunction

	task automatic expect_value(input string name, input logic [31:0] got,
	                            input logic [31:0] exp);
		checks++;
		assert (got === exp)
		else begin
			$display("[FAIL] %0t %s got 0x%0h expected 0x%0h", $time, name, got, exp);
			errors++;
		end
	endtask

	task automatic end_test(input string name);
		tests++;
		$display("test %0d %s: %s", tests, name, (errors == test_err0) ? "ok" : "FAILED");
		test_err0 = errors;
	endtask

	// One APB transfer, setup then access, response sampled mid access cycle
	task automatic apb_transfer(input logic wr, input uart_pkg::apb_addr_t addr,
	                            input uart_pkg::apb_data_t wdata);
		int waits;
		waits = 0;
		@(negedge clk);
		apb_req.paddr   = addr;
		apb_req.pwrite  = wr;
		apb_req.pwdata  = wdata;
		apb_req.psel    = 1'b1;
		apb_req.penable = 1'b0;
		@(negedge clk);
		apb_req.penable = 1'b1;
		#1;
		while (!apb_rsp.pready && waits < MAX_POLLS) begin
			@(negedge clk);
			#1;
			waits++;
		end
		if (!apb_rsp.pready) begin
			$display("APB transfer to offset 0x%0h never completed", addr);
			errors++;
		end
		rdata  = apb_rsp.prdata;
		slverr = apb_rsp.pslverr;
		@(negedge clk);
		acc_cyc         = cyc;
		apb_req.psel    = 1'b0;
		apb_req.penable = 1'b0;
	endtask

	task automatic wait_status(input uart_pkg::apb_data_t mask,
	                           input uart_pkg::apb_data_t value, input string what);
		int polls;
		polls = 0;
		apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
		while ((rdata & mask) != value && polls < MAX_POLLS) begin
			apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
			polls++;
		end
		if ((rdata & mask) != value) begin
			$display("Timeout waiting for %s in STATUS", what);
			errors++;
		end
	endtask

	task automatic wait_frames(input int n);
		int cycles;
		cycles = 0;
		while (mon_count < n && cycles < FRAME_TO) begin
			@(negedge clk);
			cycles++;
		end
		if (mon_count < n) begin
			$display("Timeout waiting for frame %0d on txd", n);
			errors++;
		end
	endtask

	// Drives a whole frame straight onto rxd
	task automatic send_frame(input uart_pkg::byte_t data, input logic stop);
		logic [9:0] bits;
		bits = {stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			@(negedge clk);
			drv_rxd = bits[i];
			repeat (CLK_DIV - 1) @(negedge clk);
		end
		@(negedge clk);
		drv_rxd = 1'b1; // Back to idle
	endtask

	initial begin
		int waits;
		int frames;
		apb_req  = '0;
		loopback = 1'b0;
		drv_rxd  = 1'b1;
		waits    = 0;
		while (rstn !== 1'b1 && waits < 100) begin
			@(negedge clk);
			waits++;
		end
		if (rstn !== 1'b1) begin
			$display("Reset was never released");
			errors++;
		end

		expect_value("txd", txd, 32'h1);
		apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
		expect_value("STATUS", rdata, 32'h1); // tx_ready only
		expect_value("pslverr", slverr, 32'h0);
		apb_transfer(1'b0, uart_pkg::REG_RXDATA, 32'h0);
		expect_value("pslverr", slverr, 32'h0);
		end_test("reset state");

		b0 = rand_byte();
		apb_transfer(1'b1, uart_pkg::REG_TXDATA, {24'b0, b0});
		expect_value("pslverr", slverr, 32'h0);
		wait_frames(1);
		expect_value("txd start delay", mon_start_cyc - acc_cyc, 32'd3);
		expect_value("txd byte", mon_byte, b0);
		expect_value("txd stop bit", mon_stop, 32'h1);
		expect_value("txd bit timing", mon_width_ok, 32'h1);
		wait_status(32'h1, 32'h1, "tx_ready");
		end_test("transmit frame");

		loopback = 1'b1;
		for (int i = 0; i < 8; i++) begin
			b0 = rand_byte();
			apb_transfer(1'b1, uart_pkg::REG_TXDATA, {24'b0, b0});
			wait_status(32'h2, 32'h2, "rx_valid");
			apb_transfer(1'b0, uart_pkg::REG_RXDATA, 32'h0);
			expect_value("RXDATA", rdata, {24'b0, b0});
			apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
			expect_value("STATUS rx flags", rdata & 32'he, 32'h0); // Cleared by the read
			wait_status(32'h1, 32'h1, "tx_ready");
		end
		end_test("loopback");

		loopback = 1'b0;
		b0       = rand_byte();
		b1       = ~b0;        // Differs in every bit
		frames   = mon_count;
		apb_transfer(1'b1, uart_pkg::REG_TXDATA, {24'b0, b0});
		expect_value("pslverr", slverr, 32'h0);
		apb_transfer(1'b1, uart_pkg::REG_TXDATA, {24'b0, b1});
		expect_value("pslverr busy write", slverr, 32'h1);
		wait_frames(frames + 1);
		expect_value("txd byte", mon_byte, b0);
		apb_transfer(1'b0, 4'hc, 32'h0);
		expect_value("pslverr unknown offset", slverr, 32'h1);
		apb_transfer(1'b0, uart_pkg::REG_TXDATA, 32'h0);
		expect_value("pslverr TXDATA read", slverr, 32'h1);
		wait_status(32'h1, 32'h1, "tx_ready");
		end_test("busy write and bad access");

		loopback = 1'b1;
		b0       = rand_byte();
		b1       = rand_byte();
		apb_transfer(1'b1, uart_pkg::REG_TXDATA, {24'b0, b0});
		wait_status(32'h3, 32'h3, "tx_ready with rx_valid");
		apb_transfer(1'b1, uart_pkg::REG_TXDATA, {24'b0, b1});
		wait_status(32'h4, 32'h4, "rx_overrun");
		apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
		expect_value("STATUS rx flags", rdata & 32'he, 32'h6); // Valid and overrun
		apb_transfer(1'b0, uart_pkg::REG_RXDATA, 32'h0);
		expect_value("RXDATA", rdata, {24'b0, b1});
		apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
		expect_value("STATUS rx flags", rdata & 32'he, 32'h0);
		wait_status(32'h1, 32'h1, "tx_ready");
		end_test("overrun");

		loopback = 1'b0;
		b0       = rand_byte();
		send_frame(b0, 1'b0);  // Stop bit low
		wait_status(32'h8, 32'h8, "rx_frame_err");
		apb_transfer(1'b0, uart_pkg::REG_RXDATA, 32'h0);
		expect_value("RXDATA", rdata, {24'b0, b0});
		apb_transfer(1'b0, uart_pkg::REG_STATUS, 32'h0);
		expect_value("STATUS rx flags", rdata & 32'he, 32'h0);
		end_test("framing error");

		$display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
		if (errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

/* test/uart_tb_clock.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tb_clock (
	output logic clk,
	output logic rstn
);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	// Low for 16 cycles, released away from the rising edge
	initial begin
		rstn = 1'b0;
		repeat (16) @(posedge clk);
		@(negedge clk);
		rstn = 1'b1;
	end

endmodule

`default_nettype wire

/* source/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top #(
	parameter int CLK_DIV = 104 // Clocks per bit, shared by both directions
)(
	input  wire                      clk,
	input  wire                      rstn,
	input  wire uart_pkg::apb_req_t  apb_req,
	input  wire                      rxd,
	output wire uart_pkg::apb_rsp_t  apb_rsp,
	output wire                      txd
);

	logic               tx_start;
	logic               tx_ready;
	uart_pkg::byte_t    tx_data;
	uart_pkg::rx_byte_t rx_byte; // Receiver result to the register file

	uart_apb_regs u_regs (
		.clk     (clk),
		.rstn    (rstn),
		.req     (apb_req),
		.tx_ready(tx_ready),
		.rx      (rx_byte),
		.rsp     (apb_rsp),
		.tx_start(tx_start),
		.tx_data (tx_data)
	);

	uart_tx #(
		.CLK_DIV(CLK_DIV)
	) u_tx (
		.clk  (clk),
		.rstn (rstn),
		.start(tx_start),
		.data (tx_data),
		.txd  (txd),
		.ready(tx_ready)
	);

	uart_rx #(
		.CLK_DIV(CLK_DIV)
	) u_rx (
		.clk (clk),
		.rstn(rstn),
		.rxd (rxd),
		.rx  (rx_byte)
	);

endmodule

`default_nettype wire

/* source/uart_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_apb_regs (
	input  wire                      clk,
	input  wire                      rstn,
	input  wire uart_pkg::apb_req_t  req,
	input  wire                      tx_ready,
	input  wire uart_pkg::rx_byte_t  rx,
	output uart_pkg::apb_rsp_t       rsp,
	output logic                     tx_start, // One-cycle pulse to the transmitter
	output uart_pkg::byte_t          tx_data
);

	logic                access; // Access phase
	logic                rd;
	logic                known;  // Offset decodes
	logic                tx_wr;  // TXDATA write, accepted or not
	logic                tx_ok;
	logic                rx_rd;  // RXDATA read, clears rx flags
	logic                rx_valid;
	logic                rx_overrun;
	logic                rx_ferr;
	uart_pkg::byte_t     rx_data;
	uart_pkg::apb_data_t status;

	assign access = req.psel && req.penable;
	assign rd     = access && !req.pwrite;
	assign known  = (req.paddr == uart_pkg::REG_TXDATA) ||
	                (req.paddr == uart_pkg::REG_STATUS) ||
	                (req.paddr == uart_pkg::REG_RXDATA);
	assign tx_wr  = access && req.pwrite && (req.paddr == uart_pkg::REG_TXDATA);
	assign tx_ok  = tx_wr && tx_ready; // Busy transmitter drops the byte
	assign rx_rd  = rd && (req.paddr == uart_pkg::REG_RXDATA);

	assign status = {28'b0, rx_ferr, rx_overrun, rx_valid, tx_ready};

	always_comb begin
		rsp.pready  = 1'b1;
		rsp.pslverr = access && (!known ||
		              (rd && req.paddr == uart_pkg::REG_TXDATA) ||
		              (tx_wr && !tx_ready));
		rsp.prdata  = '0;
		if (rd) begin
			case (req.paddr)
				uart_pkg::REG_STATUS: rsp.prdata = status;
				uart_pkg::REG_RXDATA: rsp.prdata = {24'b0, rx_data};
				default:              rsp.prdata = '0;
			endcase
		end
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			tx_start <= 1'b0;
		else
			tx_start <= tx_ok;
	end

	always_ff @(posedge clk) begin
		if (tx_ok)
			tx_data <= req.pwdata[7:0];
	end

	// Sticky receive flags, a new byte wins over a same-cycle read
	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			rx_valid   <= 1'b0;
			rx_overrun <= 1'b0;
			rx_ferr    <= 1'b0;
		end else if (rx.valid) begin
			rx_valid   <= 1'b1;
			rx_overrun <= (rx_overrun | rx_valid) & ~rx_rd; // Unread byte lost
			rx_ferr    <= rx.frame_err;
		end else if (rx_rd) begin
			rx_valid   <= 1'b0;
			rx_overrun <= 1'b0;
			rx_ferr    <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rx.valid)
			rx_data <= rx.data; // Overwrites on overrun
	end

	// Pulse is a cycle late, transmitter must still be idle
	start_when_ready: assert property (@(posedge clk) disable iff (!rstn)
		$rose(tx_start) |-> tx_ready)
		else $error("tx_start raised while transmitter busy");

endmodule

`default_nettype wire

/* source/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx #(
	parameter int CLK_DIV = 104 // Clocks per bit
)(
	input  wire                  clk,
	input  wire                  rstn,
	input  wire                  rxd, // Asynchronous serial input
	output uart_pkg::rx_byte_t   rx
);

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;
	localparam logic [CNT_W-1:0] HALF = CNT_W'(CLK_DIV / 2 - 1); // Edge to mid start bit
	localparam logic [CNT_W-1:0] FULL = CNT_W'(CLK_DIV - 1);     // Mid bit to mid bit

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START, // Waiting for mid start bit
		RX_DATA,
		RX_STOP
	} rx_state_t;

	rx_state_t        state;
	logic [2:0]       sync;   // Two sync flops plus one for edge detect
	logic             fall;
	logic             mid;    // Sample point reached
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bitn;   // Data bit index
	uart_pkg::byte_t  shreg;
	logic             valid_q;
	logic             ferr_q;

	assign fall = sync[2] & ~sync[1];
	assign mid  = (cnt == '0);

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			sync <= '1; // Idle level
		else
			sync <= {sync[1:0], rxd};
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			state   <= RX_IDLE;
			cnt     <= '0;
			bitn    <= '0;
			valid_q <= 1'b0;
		end else begin
			valid_q <= 1'b0;
			if (cnt != '0)
				cnt <= cnt - 1'b1;
			case (state)
				RX_IDLE: begin
					if (fall) begin
						state <= RX_START;
						cnt   <= HALF;
					end
				end
				RX_START: begin
					if (mid) begin
						if (!sync[1]) begin // Still low, real start bit
							state <= RX_DATA;
							cnt   <= FULL;
							bitn  <= '0;
						end else begin
							state <= RX_IDLE; // Glitch
						end
					end
				end
				RX_DATA: begin
					if (mid) begin
						cnt  <= FULL;
						bitn <= bitn + 1'b1;
						if (bitn == 3'd7)
							state <= RX_STOP;
					end
				end
				RX_STOP: begin
					if (mid) begin
						valid_q <= 1'b1; // Result with the stop sample
						state   <= RX_IDLE;
					end
				end
				default: state <= RX_IDLE;
			endcase
		end
	end

	// Data path, LSB arrives first
	always_ff @(posedge clk) begin
		if (state == RX_DATA && mid)
			shreg <= {sync[1], shreg[7:1]};
		if (state == RX_STOP && mid)
			ferr_q <= ~sync[1]; // Stop must be high
	end

	assign rx.valid     = valid_q;
	assign rx.data      = shreg;
	assign rx.frame_err = ferr_q;

	valid_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
		rx.valid |=> !rx.valid)
		else $error("rx valid held longer than one cycle");

endmodule

`default_nettype wire

/* uart_tx/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx #(
	parameter int CLK_DIV = 104 // Clocks per bit
)(
	input  wire                 clk,
	input  wire                 rstn,
	input  wire                 start, // One-cycle request from the register file
	input  wire uart_pkg::byte_t data,
	output logic                txd,   // Serial line, idles high
	output logic                ready  // High only in IDLE
);

	uart_pkg::tx_state_t state;
	uart_pkg::tx_state_t next_state;
	uart_pkg::byte_t     data_r;   // Byte captured at start
	logic [9:0]          shifter;  // Stop, data, start; LSB goes out first
	logic [3:0]          bitc;     // Ticks since load
	logic                load;
	logic                baud_en;
	logic                tick;

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			state <= uart_pkg::IDLE;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		load       = 1'b0;
		baud_en    = 1'b0;
		ready      = 1'b0;
		case (state)
			uart_pkg::IDLE: begin
				ready = 1'b1;
				if (start)
					next_state = uart_pkg::START;
			end
			uart_pkg::START: begin // Exactly one cycle
				load       = 1'b1;
				baud_en    = 1'b1;
				next_state = uart_pkg::TRANS;
			end
			uart_pkg::TRANS: begin
				baud_en = 1'b1;
				// Stop bit done plus one idle period
				if (bitc == 4'd11)
					next_state = uart_pkg::IDLE;
			end
			default: next_state = uart_pkg::IDLE;
		endcase
	end

	// Only sampled in IDLE, a busy start leaves it alone
	always_ff @(posedge clk) begin
		if (start && state == uart_pkg::IDLE)
			data_r <= data;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			shifter <= '1;
		else if (load)
			shifter <= {1'b1, data_r, 1'b0}; // Start bit sits at bit 0
		else if (tick)
			shifter <= {1'b1, shifter[9:1]}; // Back-fill with idle level
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			bitc <= '0;
		else if (load)
			bitc <= '0;
		else if (tick)
			bitc <= bitc + 1'b1;
	end

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn)
			txd <= 1'b1; // Line idles high
		else
			txd <= shifter[0]; // Output flop, one cycle behind the shifter
	end

	uart_baud_gen #(
		.CLK_DIV(CLK_DIV)
	) u_baud (
		.clk (clk),
		.rstn(rstn),
		.ena (baud_en),
		.tick(tick)
	);

	// Each data bit leaves from the byte latched at start
	busy_keeps_byte: assert property (@(posedge clk) disable iff (!rstn)
		state == uart_pkg::TRANS && bitc >= 4'd1 && bitc <= 4'd8 |->
			shifter[0] == data_r[3'(bitc - 4'd1)])
		else $error("data bit on the shifter differs from the latched byte");

endmodule

`default_nettype wire

/* uart_tx/uart_baud_gen.sv */
`timescale 1ns/1ps
`default_nettype none

// Bit-rate tick, one clock wide, every CLK_DIV clocks while enabled
module uart_baud_gen #(
	parameter int CLK_DIV = 104 // Clocks per bit
)(
	input  wire  clk,
	input  wire  rstn,
	input  wire  ena,  // Low holds the divider cleared
	output logic tick
);

	localparam int CNT_W = (CLK_DIV > 1) ? $clog2(CLK_DIV) : 1;

	logic [CNT_W-1:0] cnt;
	logic             wrap;

	assign wrap = (cnt == CNT_W'(CLK_DIV - 1)); // Last clock of the period

	always_ff @(posedge clk or negedge rstn) begin
		if (!rstn) begin
			cnt  <= '0;
			tick <= 1'b0;
		end else if (!ena) begin
			cnt  <= '0; // Restart phase on every enable
			tick <= 1'b0;
		end else begin
			tick <= wrap; // Registered, so first tick lands CLK_DIV after enable
			cnt  <= wrap ? '0 : cnt + 1'b1;
		end
	end

	// The transmitter must drop enable away from a wrap
	tick_needs_ena: assert property (@(posedge clk) disable iff (!rstn)
		$rose(tick) |-> ena)
		else $error("baud tick rose with generator disabled");

endmodule

`default_nettype wire

/* common/uart_pkg.sv */
`default_nettype none

package uart_pkg;

	typedef logic [7:0]  byte_t;     // One serial payload byte
	typedef logic [3:0]  apb_addr_t; // Register offset
	typedef logic [31:0] apb_data_t; // APB data word

	// Master side of the APB bus
	typedef struct packed {
		apb_addr_t paddr;
		logic      psel;
		logic      penable;
		logic      pwrite;
		apb_data_t pwdata;
	} apb_req_t;

	// Slave side of the APB bus
	typedef struct packed {
		apb_data_t prdata;
		logic      pready;  // Tied high, no wait states
		logic      pslverr;
	} apb_rsp_t;

	// Receiver result
	typedef struct packed {
		logic  valid;     // One-cycle pulse
		byte_t data;
		logic  frame_err; // Stop bit was 0
	} rx_byte_t;

	typedef enum logic [1:0] {
		IDLE,  // Line high, waiting for start
		START, // Single cycle, loads the shifter
		TRANS  // Bits going out
	} tx_state_t;

	localparam apb_addr_t REG_TXDATA = 4'h0; // Write only
	localparam apb_addr_t REG_STATUS = 4'h4; // Read only
	localparam apb_addr_t REG_RXDATA = 4'h8; // Read only, read clears rx flags

endpackage

`default_nettype wire
